//--- flist.f
logic/fds_pkg.sv
logic/fds_timer_irq.sv
logic/fds_disk_drive.sv
logic/fds_control_regs.sv
logic/fds_mapper_top.sv
verification/fds_tb.sv

//--- logic/fds_control_regs.sv
// CPU register decode, $4023/$4025 control, status read data and PRG address map
`timescale 1ns/1ps
`default_nettype none

module fds_control_regs
	import fds_pkg::*;
(
	input  wire                clk,
	input  wire                diskreset,
	input  wire                ce,
	input  wire cpu_bus_t      bus,
	input  wire drive_status_t status,
	input  wire                timer_irq,
	input  wire disk_pos_t     disk_pos,
	output drive_ctrl_t        ctrl,
	output logic               io_enable,
	output logic               wr_data_strobe,
	output logic               rd_data_strobe,
	output logic               rd_status_strobe,
	output cpu_data_t          dout,
	output logic               bus_drive,
	output prg_addr_t          prg_aout,
	output logic               prg_allow
);

	logic        wr_tick;
	logic        rd_tick;
	logic        is_wram;
	logic [5:0]  prg_bank;
	logic [17:0] image_offset;

	assign wr_tick = ce & bus.write;
	assign rd_tick = ce & bus.read;

	always_ff @(posedge clk) begin
		if (diskreset) begin
			io_enable <= 1'b0;
			ctrl      <= '0;
		end else if (wr_tick) begin
			if (bus.addr == REG_IO_ENABLE)
				io_enable <= bus.data[0];
			if (bus.addr == REG_DISK_CTRL) begin
				ctrl.motor_on      <= bus.data[0];
				ctrl.head_rewind   <= bus.data[1];
				ctrl.read_mode     <= !bus.data[2];
				ctrl.byte_transfer <= bus.data[6];
				ctrl.disk_irq_en   <= bus.data[7];
			end
		end
	end

	assign wr_data_strobe   = wr_tick && bus.addr == REG_WRITE_DATA;
	assign rd_data_strobe   = rd_tick && bus.addr == REG_READ_DATA;
	assign rd_status_strobe = rd_tick && bus.addr == REG_IRQ_STATUS;

	// Only the status registers drive the bus and $4031 data comes from the image
	always_comb begin
		dout      = '0;
		bus_drive = bus.read;
		case (bus.addr)
			REG_IRQ_STATUS:
				dout = {1'b0, status.disk_end, 4'd0, status.byte_flag, timer_irq};
			REG_DRIVE_STATUS:
				dout = {6'b010000, !status.disk_ready, 1'b0};
			REG_EXT_STATUS:
				dout = 8'h80;   // Battery good
			default:
				bus_drive = 1'b0;
		endcase
	end

	// $6000-$DFFF
	assign is_wram = bus.addr[15] ^ (&bus.addr[14:13]);

	// Work RAM sits in banks 4-7, BIOS in bank 0
	assign prg_bank     = is_wram ? {3'b000, bus.addr[15:13] + 3'd1} : 6'd0;
	assign image_offset = SIDE0_OFFSET + {2'b00, disk_pos};

	assign prg_aout = status.disk_access ? {DISK_IMAGE_BANK, image_offset}
		: {3'b000, prg_bank, bus.addr[12:0]};

	assign prg_allow = (bus.read && bus.addr[15]) || is_wram || status.disk_access;

endmodule

`default_nettype wire

//--- logic/fds_disk_drive.sv
// Drive byte timing, disk position counter and block-end tracking
`timescale 1ns/1ps
`default_nettype none

module fds_disk_drive
	import fds_pkg::*;
(
	input  wire              clk,
	input  wire              diskreset,
	input  wire              ce,
	input  wire cpu_bus_t    bus,
	input  wire cpu_data_t   disk_byte,
	input  wire drive_ctrl_t ctrl,
	input  wire              wr_data_strobe,
	input  wire              rd_data_strobe,
	input  wire              rd_status_strobe,
	output drive_status_t    status,
	output disk_pos_t        disk_pos,
	output logic             disk_irq
);

	logic [15:0] xfer_cnt_q;
	disk_pos_t   byte_cnt_q;     // Bytes into the current block
	disk_pos_t   file_size_q;
	logic [2:0]  block_type_q;
	logic        block_end_q;
	logic        after_pre_gap_q;
	logic        byte_flag_q;
	logic        new_byte_q;
	logic        got_start_q;
	logic        got_start_d_q;
	logic        status_read_q;
	logic        read_d_q;
	logic        write_d_q;

	logic        read_access;
	logic        write_access;
	logic        read_tick;
	logic        write_tick;
	logic        xfer_start;
	logic        byte_slot;
	logic        block_done;
	logic        disk_end;
	cpu_data_t   disk_data;

	assign read_access  = bus.read && bus.addr == REG_READ_DATA;
	assign write_access = bus.write && bus.addr == REG_WRITE_DATA && !ctrl.read_mode &&
		ctrl.byte_transfer && got_start_d_q && ctrl.motor_on && !ctrl.head_rewind &&
		!block_end_q;
	assign read_tick  = rd_data_strobe & ctrl.read_mode;
	assign write_tick = wr_data_strobe & write_access;
	assign disk_data  = write_access ? bus.data : disk_byte;

	// Rising edge of the transfer bit in a $4025 write
	assign xfer_start = ce && bus.write && bus.addr == REG_DISK_CTRL && bus.data[6] &&
		!ctrl.byte_transfer;

	assign byte_slot = ctrl.motor_on && !ctrl.head_rewind && (after_pre_gap_q ?
		(xfer_cnt_q == BYTE_DELAY && !xfer_start) : xfer_cnt_q == PRE_GAP_DELAY);

	// Image files drop the CRC bytes, so block length comes from the header
	always_comb begin
		case (block_type_q)
			3'd1:    block_done = byte_cnt_q == 16'h0037;
			3'd2:    block_done = byte_cnt_q == 16'h0001;
			3'd3:    block_done = byte_cnt_q == 16'h000F;
			3'd4:    block_done = byte_cnt_q == file_size_q;
			default: block_done = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if ((read_tick || write_tick) && block_type_q == 3'd3) begin
			if (byte_cnt_q == 16'h000D)
				file_size_q[7:0] <= disk_data;
			if (byte_cnt_q == 16'h000E)
				file_size_q[15:8] <= disk_data;
		end
	end

	always_ff @(posedge clk) begin
		if (diskreset) begin
			xfer_cnt_q      <= '0;
			byte_cnt_q      <= '0;
			block_type_q    <= '0;
			block_end_q     <= 1'b0;
			after_pre_gap_q <= 1'b0;
			byte_flag_q     <= 1'b0;
			new_byte_q      <= 1'b0;
			got_start_q     <= 1'b0;
			got_start_d_q   <= 1'b0;
			status_read_q   <= 1'b0;
			read_d_q        <= 1'b0;
			write_d_q       <= 1'b0;
			disk_pos        <= '0;
		end else if (ce) begin
			status_read_q <= rd_status_strobe;
			read_d_q      <= rd_data_strobe;
			write_d_q     <= write_tick;
			got_start_d_q <= got_start_q;

			if (wr_data_strobe) begin
				byte_flag_q <= 1'b0;
				if (!ctrl.read_mode && ctrl.byte_transfer && bus.data == START_BYTE)
					got_start_q <= 1'b1;
			end

			if (xfer_start) begin
				byte_flag_q   <= !ctrl.read_mode;   // Writes get their first byte request at once
				new_byte_q    <= 1'b0;
				got_start_q   <= 1'b0;
				got_start_d_q <= 1'b0;
				byte_cnt_q    <= '0;
				block_end_q   <= 1'b0;
				block_type_q  <= '0;
			end

			if ((read_tick || write_tick) && byte_cnt_q == '0)
				block_type_q <= disk_data[2:0];

			if (status_read_q || read_d_q)
				byte_flag_q <= 1'b0;

			// Position moves one tick after the byte was taken
			if (((read_d_q && ctrl.read_mode) || write_d_q) && new_byte_q) begin
				new_byte_q <= 1'b0;
				byte_cnt_q <= byte_cnt_q + 1'b1;
				if (!disk_end && !block_end_q)
					disk_pos <= disk_pos + 1'b1;
				if (block_done)
					block_end_q <= 1'b1;
			end

			if (!ctrl.motor_on) begin
				xfer_cnt_q <= '0;
			end else if (ctrl.head_rewind) begin
				xfer_cnt_q      <= '0;
				disk_pos        <= '0;
				after_pre_gap_q <= 1'b0;
			end else if (byte_slot || (after_pre_gap_q && xfer_start)) begin
				xfer_cnt_q      <= '0;
				after_pre_gap_q <= 1'b1;
			end else begin
				xfer_cnt_q <= xfer_cnt_q + 1'b1;
			end

			if (byte_slot && ctrl.byte_transfer) begin
				byte_flag_q <= 1'b1;
				new_byte_q  <= 1'b1;
			end
		end
	end

	assign disk_end = disk_pos == DISK_END_POS;
	assign disk_irq = byte_flag_q & ctrl.disk_irq_en;

	assign status = '{
		byte_flag:   byte_flag_q,
		disk_end:    disk_end,
		disk_ready:  ctrl.motor_on && !ctrl.head_rewind && !disk_end,
		disk_access: read_access || write_access
	};

endmodule

`default_nettype wire

//--- logic/fds_mapper_top.sv
// Disk drive side of the FDS mapper: registers, interval timer and drive engine
`timescale 1ns/1ps
`default_nettype none

module fds_mapper_top
	import fds_pkg::*;
(
	input  wire            clk,
	input  wire            diskreset,
	input  wire            ce,          // CPU cycle enable
	input  wire cpu_bus_t  bus,
	input  wire cpu_data_t disk_byte,   // Byte fetched from the disk image
	output cpu_data_t      dout,
	output logic           bus_drive,
	output prg_addr_t      prg_aout,
	output logic           prg_allow,
	output logic           irq
);

	drive_ctrl_t   ctrl;
	drive_status_t status;
	disk_pos_t     disk_pos;
	logic          io_enable;
	logic          wr_data_strobe;
	logic          rd_data_strobe;
	logic          rd_status_strobe;
	logic          timer_irq;
	logic          disk_irq;

	fds_control_regs u_regs (
		.clk              (clk),
		.diskreset        (diskreset),
		.ce               (ce),
		.bus              (bus),
		.status           (status),
		.timer_irq        (timer_irq),
		.disk_pos         (disk_pos),
		.ctrl             (ctrl),
		.io_enable        (io_enable),
		.wr_data_strobe   (wr_data_strobe),
		.rd_data_strobe   (rd_data_strobe),
		.rd_status_strobe (rd_status_strobe),
		.dout             (dout),
		.bus_drive        (bus_drive),
		.prg_aout         (prg_aout),
		.prg_allow        (prg_allow)
	);

	fds_timer_irq u_timer (
		.clk              (clk),
		.diskreset        (diskreset),
		.ce               (ce),
		.bus              (bus),
		.io_enable        (io_enable),
		.rd_status_strobe (rd_status_strobe),
		.timer_irq        (timer_irq)
	);

	fds_disk_drive u_drive (
		.clk              (clk),
		.diskreset        (diskreset),
		.ce               (ce),
		.bus              (bus),
		.disk_byte        (disk_byte),
		.ctrl             (ctrl),
		.wr_data_strobe   (wr_data_strobe),
		.rd_data_strobe   (rd_data_strobe),
		.rd_status_strobe (rd_status_strobe),
		.status           (status),
		.disk_pos         (disk_pos),
		.disk_irq         (disk_irq)
	);

	assign irq = timer_irq | disk_irq;   // Shared CPU IRQ line

endmodule

`default_nettype wire

//--- logic/fds_pkg.sv
// Disk drive types, CPU bus and drive structs, register map and transfer timing
`default_nettype none

package fds_pkg;

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;
	typedef logic [21:0] prg_addr_t;
	typedef logic [15:0] disk_pos_t;   // Byte offset within the disk side
	typedef logic [15:0] timer_t;

	typedef struct packed {
		cpu_addr_t addr;
		cpu_data_t data;    // Write data from the CPU
		logic      read;
		logic      write;
	} cpu_bus_t;

	// Fields of the $4025 control register
	typedef struct packed {
		logic motor_on;
		logic head_rewind;
		logic read_mode;       // Set when bit 2 is written low
		logic byte_transfer;
		logic disk_irq_en;
	} drive_ctrl_t;

	typedef struct packed {
		logic byte_flag;       // Byte ready for the CPU
		logic disk_end;
		logic disk_ready;
		logic disk_access;     // CPU touches the disk image this cycle
	} drive_status_t;

	localparam cpu_addr_t REG_TIMER_LO     = 16'h4020;
	localparam cpu_addr_t REG_TIMER_HI     = 16'h4021;
	localparam cpu_addr_t REG_TIMER_CTRL   = 16'h4022;
	localparam cpu_addr_t REG_IO_ENABLE    = 16'h4023;
	localparam cpu_addr_t REG_WRITE_DATA   = 16'h4024;
	localparam cpu_addr_t REG_DISK_CTRL    = 16'h4025;
	localparam cpu_addr_t REG_IRQ_STATUS   = 16'h4030;
	localparam cpu_addr_t REG_READ_DATA    = 16'h4031;
	localparam cpu_addr_t REG_DRIVE_STATUS = 16'h4032;
	localparam cpu_addr_t REG_EXT_STATUS   = 16'h4033;

	// Much shorter than a real drive
	localparam logic [15:0] PRE_GAP_DELAY = 16'd1023;
	localparam logic [15:0] BYTE_DELAY    = 16'd99;

	localparam disk_pos_t   DISK_END_POS    = 16'd65499;
	localparam logic [17:0] SIDE0_OFFSET    = 18'd16;    // Skips the image file header
	localparam logic [3:0]  DISK_IMAGE_BANK = 4'b1111;
	localparam cpu_data_t   START_BYTE      = 8'h80;

endpackage

`default_nettype wire

//--- logic/fds_timer_irq.sv
// Interval timer with one-shot or repeating IRQ
`timescale 1ns/1ps
`default_nettype none

module fds_timer_irq
	import fds_pkg::*;
(
	input  wire           clk,
	input  wire           diskreset,
	input  wire           ce,
	input  wire cpu_bus_t bus,
	input  wire           io_enable,
	input  wire           rd_status_strobe,
	output logic          timer_irq
);

	timer_t latch_q;
	timer_t count_q;
	logic   irq_en_q;
	logic   repeat_q;
	logic   status_read_q;   // $4030 was read on the previous tick
	logic   wr_tick;

	assign wr_tick = ce & bus.write;

	always_ff @(posedge clk) begin
		if (wr_tick && bus.addr == REG_TIMER_LO)
			latch_q[7:0] <= bus.data;
		if (wr_tick && bus.addr == REG_TIMER_HI)
			latch_q[15:8] <= bus.data;
	end

	always_ff @(posedge clk) begin
		if (diskreset) begin
			count_q       <= '0;
			irq_en_q      <= 1'b0;
			repeat_q      <= 1'b0;
			status_read_q <= 1'b0;
			timer_irq     <= 1'b0;
		end else if (ce) begin
			status_read_q <= rd_status_strobe;

			if (irq_en_q) begin
				if (count_q == '0) begin
					timer_irq <= 1'b1;
					count_q   <= latch_q;   // Reload for repeat mode
					if (!repeat_q)
						irq_en_q <= 1'b0;
				end else begin
					count_q <= count_q - 1'b1;
				end
			end

			if (status_read_q)
				timer_irq <= 1'b0;

			if (wr_tick && bus.addr == REG_TIMER_CTRL) begin
				repeat_q <= bus.data[0];
				irq_en_q <= bus.data[1] & io_enable;
				if (bus.data[1] && io_enable)
					count_q <= latch_q;
				else
					timer_irq <= 1'b0;
			end

			// Disabled register block kills the timer
			if (!io_enable) begin
				irq_en_q  <= 1'b0;
				timer_irq <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the FDS disk drive testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module fds_tb -f flist.f -Mdir obj_dir -o fds_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/fds_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qxF '*** PASSED ***'; then
	exit 0
fi
exit 1

//--- verification/fds_tb.sv
// Testbench for the FDS disk drive core, driven by the vector file, with LFSR idle filler
`timescale 1ns/1ps
`default_nettype none

module fds_tb
	import fds_pkg::*;
();

	logic      clk;
	logic      diskreset;
	logic      ce;
	cpu_bus_t  bus;
	cpu_data_t disk_byte;
	cpu_data_t dout;
	logic      bus_drive;
	prg_addr_t prg_aout;
	logic      prg_allow;
	logic      irq;

	logic [15:0] lfsr;
	string       cur_name = "";
	int          checks = 0;
	int          errors = 0;
	int          test_errors = 0;
	int          tests = 0;
	int          failed_tests = 0;

	fds_mapper_top DUT (
		.clk       (clk),
		.diskreset (diskreset),
		.ce        (ce),
		.bus       (bus),
		.disk_byte (disk_byte),
		.dout      (dout),
		.bus_drive (bus_drive),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow),
		.irq       (irq)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// Nibble-aligned so the vector file stays readable
	function automatic logic [39:0] observe();
		return {3'b000, bus_drive, 3'b000, prg_allow, dout, 2'b00, prg_aout};
	endfunction

	// Drive just after the rising edge and sample on the falling edge
	task automatic bus_cycle(input logic rd, input logic wr, input cpu_addr_t addr,
		input cpu_data_t data, input cpu_data_t dbyte);
		@(posedge clk);
		#1;
		bus       = '{addr: addr, data: data, read: rd, write: wr};
		disk_byte = dbyte;
		@(negedge clk);
	endtask

	task automatic filler_cycle();
		logic [7:0] low;
		for (int i = 0; i < 8; i++) begin
			lfsr   = lfsr_next(lfsr);
			low[i] = lfsr[0];
		end
		bus_cycle(1'b1, 1'b0, {8'h50, low}, 8'h00, 8'h00);   // Nothing decodes at $50xx
	endtask

	task automatic check_value(input string name, input logic [39:0] exp,
		input logic [39:0] act);
		checks++;
		assert (act === exp)
		else begin
			$display("FAILED %s: expected %0h, actual %0h", name, exp, act);
			test_errors++;
		end
	endtask

	// Rising edge of irq with a limit on each half
	task automatic wait_irq(input string name, input int limit);
		int n;
		n = 0;
		while (irq === 1'b1 && n < limit) begin
			filler_cycle();
			n++;
		end
		checks++;
		assert (n < limit)
		else begin
			$display("TIMEOUT in %s: irq stayed high for %0d cycles", name, limit);
			test_errors++;
		end
		n = 0;
		while (irq !== 1'b1 && n < limit) begin
			filler_cycle();
			n++;
		end
		checks++;
		assert (n < limit)
		else begin
			$display("TIMEOUT in %s: irq did not rise within %0d cycles", name, limit);
			test_errors++;
		end
	endtask

	task automatic finish_test();
		if (cur_name != "") begin
			tests++;
			if (test_errors == 0) begin
				$display("test %s: ok", cur_name);
			end else begin
				$display("test %s: %0d errors", cur_name, test_errors);
				failed_tests++;
			end
			errors += test_errors;
			test_errors = 0;
		end
	endtask

	initial begin
		int          fd;
		int          code;
		string       line;
		string       op;
		string       name;
		logic [15:0] addr;
		logic [31:0] data;
		logic [39:0] exp;

		lfsr      = 16'd31;
		diskreset = 1'b1;
		ce        = 1'b1;
		bus       = '0;
		disk_byte = '0;
		repeat (4) @(posedge clk);
		#1;
		diskreset = 1'b0;

		fd = $fopen("verification/fds_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file verification/fds_vectors.txt");
			errors++;
		end

		while (fd != 0 && !$feof(fd)) begin
			code = $fgets(line, fd);
			if (code == 0 || line.len() < 2 || line[0] == "#")
				continue;
			code = $sscanf(line, "%s %h %h %h %s", op, addr, data, exp, name);
			if (code != 5) begin
				$display("malformed vector line: %s", line);
				errors++;
				continue;
			end
			if (name != cur_name) begin
				finish_test();
				cur_name = name;
			end
			if (op == "write") begin
				bus_cycle(1'b0, 1'b1, addr, data[7:0], 8'h00);
			end else if (op == "read") begin
				bus_cycle(1'b1, 1'b0, addr, 8'h00, data[7:0]);   // Data field feeds the disk
				check_value(name, exp, observe());
			end else if (op == "idle") begin
				for (int i = 0; i < data; i++) begin
					filler_cycle();
					check_value(name, exp, {39'd0, irq});
				end
			end else if (op == "wait_irq") begin
				wait_irq(name, data);
			end else begin
				$display("unknown operation %s in test %s", op, name);
				test_errors++;
			end
		end
		if (fd != 0)
			$fclose(fd);
		finish_test();

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests, failed_tests, checks, errors);
		if (errors == 0 && tests > 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/fds_vectors.txt
# op addr data expected name, all numbers hex; read: data drives disk_byte
# read expects {bus_drive, prg_allow, dout, prg_aout}; idle: data cycles, expected irq; wait_irq: data timeout
write 4023 01 0 timer_oneshot
write 4020 05 0 timer_oneshot
write 4021 00 0 timer_oneshot
write 4022 02 0 timer_oneshot
idle 0 6 0 timer_oneshot
idle 0 3 1 timer_oneshot
read 4030 00 1001000030 timer_oneshot
idle 0 1 1 timer_oneshot
idle 0 3 0 timer_oneshot
write 4023 00 0 timer_disabled
write 4022 02 0 timer_disabled
idle 0 14 0 timer_disabled
read 4032 00 1042000032 drive_status
write 4025 01 0 drive_status
read 4032 00 1040000032 drive_status
read 4033 00 1080000033 drive_status
write 4025 c1 0 disk_read
wait_irq 0 800 0 disk_read
read 4030 00 1002000030 disk_read
read 4031 02 01003c0010 disk_read
wait_irq 0 100 0 block_end
read 4031 5a 01003c0011 block_end
wait_irq 0 100 0 block_end
read 4031 a5 01003c0012 block_end
wait_irq 0 100 0 block_end
read 4031 3c 01003c0012 block_end
read 6000 00 0100008000 wram_map
read dfff 00 010000ffff wram_map
read e000 00 0100000000 wram_map
read 5000 00 0000001000 wram_map
